// File: common/fetch_pkg.sv
package fetch_pkg;

    // queue geometry, one slot always left empty
    localparam int QUEUE_DEPTH = 16;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    localparam int INST_ID_W = 64;  // running id handed to decode

    // word-fetch request to instruction memory
    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    // memory response, valid for one cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] inst;
    } mem_resp_t;

    // word presented to decode
    typedef struct packed {
        logic [31:0]          addr;
        logic [31:0]          inst;
        logic [INST_ID_W-1:0] inst_id;
    } fetch_out_t;

    // fetch FSM, WAITING while a request is in flight
    typedef enum logic {
        IDLE,
        WAITING
    } fetch_state_e;

endpackage

// File: fetch/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst_n,

    input  logic redirect_valid,
    input  logic resp_valid,
    input  logic resp_match,
    input  logic q_full,
    input  logic q_empty,
    input  logic mem_req_ready,
    input  logic out_ready,

    output logic mem_req_valid,
    output logic pc_step,
    output logic q_push,
    output logic q_pop,
    output logic flush,
    output logic out_valid
);

    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;

    logic resp_done;    // outstanding request answered this cycle
    logic req_fire;     // request handshake completes

    assign resp_done = (state == WAITING) && resp_valid && resp_match;

    // new request may go out in the same cycle the old one completes
    assign mem_req_valid = !redirect_valid && !q_full &&
                           ((state == IDLE) || resp_done);

    assign req_fire = mem_req_valid && mem_req_ready;
    assign pc_step  = req_fire;

    // a redirect wins over every other strobe
    assign flush  = redirect_valid;
    assign q_push = resp_done && !redirect_valid;

    // decode never sees a word in the redirect cycle
    assign out_valid = !q_empty && !redirect_valid;
    assign q_pop     = out_valid && out_ready;

    always_comb begin
        state_next = state;
        if (redirect_valid) begin
            state_next = IDLE;          // in-flight request abandoned
        end else if (req_fire) begin
            state_next = WAITING;
        end else if (resp_done) begin
            state_next = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: fetch/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               pc_step,
    input  logic               flush,
    input  logic [31:0]        redirect_addr,

    input  fetch_pkg::mem_resp_t mem_resp,
    output fetch_pkg::mem_req_t  mem_req,
    output logic               resp_match
);

    import fetch_pkg::*;

    logic [31:0] pc;
    logic [31:0] req_addr;  // address of the request in flight
    logic [31:0] pc_next;

    // no prediction, always sequential
    assign pc_next = pc + 32'd4;

    assign mem_req.addr = pc;

    // only the answer to our own request counts
    assign resp_match = (mem_resp.addr == req_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= redirect_addr;    // mispredict target
        end else if (pc_step) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_addr <= RESET_PC;
        end else if (pc_step && !flush) begin
            req_addr <= pc;         // latch address as it is accepted
        end
    end

endmodule

// File: fetch/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  q_push,
    input  logic                  q_pop,
    input  logic                  flush,

    input  fetch_pkg::mem_resp_t  mem_resp,

    output logic                  q_full,
    output logic                  q_empty,
    output fetch_pkg::fetch_out_t out
);

    import fetch_pkg::*;

    // usable entries, one slot separates full from empty
    localparam logic [QPTR_W:0] CAPACITY = (QPTR_W + 1)'(QUEUE_DEPTH - 1);

    logic [31:0] addr_mem [QUEUE_DEPTH];
    logic [31:0] inst_mem [QUEUE_DEPTH];

    logic [QPTR_W-1:0]    head;
    logic [QPTR_W-1:0]    tail;
    logic [INST_ID_W-1:0] inst_id;

    logic [QPTR_W:0] fill_next;     // fill level after this cycle's push

    assign fill_next = {1'b0, tail - head} + {{QPTR_W{1'b0}}, q_push};

    // counts the word being written now, so a reissued request
    // always finds a free slot for its answer
    assign q_full  = (fill_next >= CAPACITY);
    assign q_empty = (head == tail);

    assign out.addr    = addr_mem[head];
    assign out.inst    = inst_mem[head];
    assign out.inst_id = inst_id;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (q_push) begin
            addr_mem[tail] <= mem_resp.addr;
            inst_mem[tail] <= mem_resp.inst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head    <= '0;
            tail    <= '0;
            inst_id <= '0;
        end else if (flush) begin
            head    <= tail;            // drop everything held
            inst_id <= inst_id + 1'b1;
        end else begin
            if (q_push) begin
                tail <= tail + 1'b1;
            end
            if (q_pop) begin
                head    <= head + 1'b1;
                inst_id <= inst_id + 1'b1;
            end
        end
    end

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // redirect from execute
    input  logic                  redirect_valid,
    input  logic [31:0]           redirect_addr,

    // instruction memory
    output logic                  mem_req_valid,
    output fetch_pkg::mem_req_t   mem_req,
    input  logic                  mem_req_ready,
    input  fetch_pkg::mem_resp_t  mem_resp,

    // decode
    output logic                  out_valid,
    output fetch_pkg::fetch_out_t out,
    input  logic                  out_ready
);

    logic resp_match;
    logic q_full;
    logic q_empty;
    logic pc_step;
    logic q_push;
    logic q_pop;
    logic flush;

    fetch_ctrl ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .resp_valid     (mem_resp.valid),
        .resp_match     (resp_match),
        .q_full         (q_full),
        .q_empty        (q_empty),
        .mem_req_ready  (mem_req_ready),
        .out_ready      (out_ready),
        .mem_req_valid  (mem_req_valid),
        .pc_step        (pc_step),
        .q_push         (q_push),
        .q_pop          (q_pop),
        .flush          (flush),
        .out_valid      (out_valid)
    );

    pc_unit pc_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_step       (pc_step),
        .flush         (flush),
        .redirect_addr (redirect_addr),
        .mem_resp      (mem_resp),
        .mem_req       (mem_req),
        .resp_match    (resp_match)
    );

    fetch_queue queue_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .q_push   (q_push),
        .q_pop    (q_pop),
        .flush    (flush),
        .mem_resp (mem_resp),
        .q_full   (q_full),
        .q_empty  (q_empty),
        .out      (out)
    );

endmodule

// File: testbench/imem_model.sv
`timescale 1ns/1ps

module imem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_req_valid,
    input  fetch_pkg::mem_req_t  mem_req,
    input  logic                 hold_ready,    // keep ready low
    input  logic                 inject_bad,    // one response with a wrong address
    output logic                 mem_req_ready,
    output fetch_pkg::mem_resp_t mem_resp
);

    import fetch_pkg::*;

    localparam logic [31:0] INST_KEY = 32'h5A5A_0000;

    logic [31:0] pend_addr [$];     // accepted, not yet answered
    int unsigned pend_due [$];
    int unsigned cycle;
    logic [31:0] last_addr;
    logic        hold_q;
    logic        inject_q;

    initial begin
        mem_req_ready = 1'b0;
        mem_resp      = '0;
        cycle         = 0;
        last_addr     = '0;
        hold_q        = 1'b0;
        inject_q      = 1'b0;
    end

    always @(posedge clk) begin
        cycle  = cycle + 1;
        hold_q = hold_ready;
        if (inject_bad) begin
            inject_q = 1'b1;
        end
        if (rst_n && mem_req_valid && mem_req_ready) begin
            pend_addr.push_back(mem_req.addr);
            pend_due.push_back(cycle + $urandom_range(0, 3));  // 1 to 4 cycles later
            last_addr = mem_req.addr;
        end
    end

    always @(negedge clk) begin
        mem_resp_t resp;
        resp = '0;
        if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
            resp.valid = 1'b1;
            resp.addr  = pend_addr.pop_front();
            resp.inst  = resp.addr ^ INST_KEY;
            void'(pend_due.pop_front());
        end else if (inject_q) begin
            resp.valid = 1'b1;
            resp.addr  = last_addr + 32'h0000_1000;    // never the address in flight
            resp.inst  = 32'hbad0_bad0;
            inject_q   = 1'b0;
        end
        mem_resp      = resp;
        mem_req_ready = !hold_q && ($urandom_range(0, 3) != 0);
    end

endmodule

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam logic [31:0] INST_KEY = 32'h5A5A_0000;
    localparam int          TIMEOUT  = 2000;    // cycles per wait loop

    logic        clk;
    logic        rst_n;
    logic        redirect_valid;
    logic [31:0] redirect_addr;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    mem_resp_t   mem_resp;
    logic        out_valid;
    fetch_out_t  out;
    logic        out_ready;
    logic        hold_ready;
    logic        inject_bad;

    // reference model and monitor state
    logic [31:0] exp_addr;
    logic [63:0] exp_id;
    logic [63:0] ref_pop_id;    // expected id of the last pop
    logic [31:0] last_pop_addr;
    logic [63:0] last_pop_id;
    int          pop_count;
    int          idle_run;      // consecutive cycles without a request
    logic        req_fired;
    logic        after_flush;
    int          errors;
    int          tests_failed;
    logic        timed_out;

    fetch_top dut_i (.*);
    imem_model mem_i (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (timed_out || errors != start_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d check errors", name, errors - start_errors);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // random out_ready until n more words have popped
    task automatic pop_words(input int n, input string what);
        int target;
        int waited;
        target = pop_count + n;
        waited = 0;
        while (!timed_out && pop_count < target) begin
            @(negedge clk);
            out_ready = ($urandom_range(0, 2) != 0);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: %s did not deliver %0d words", what, n);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_request();
        int waited;
        waited = 0;
        req_fired = 1'b0;
        while (!timed_out && !req_fired) begin
            @(negedge clk);
            out_ready = ($urandom_range(0, 2) != 0);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: no request was accepted by the memory");
                timed_out = 1'b1;
            end
        end
    endtask

    // strobes redirect for one cycle starting at a falling edge
    task automatic redirect_and_check(input logic [31:0] target);
        logic [63:0] id_before;
        id_before      = ref_pop_id;
        redirect_valid = 1'b1;
        redirect_addr  = target;
        @(negedge clk);
        redirect_valid = 1'b0;
        pop_words(1, "fetch after redirect");
        if (!timed_out) begin
            check_value("out.addr", 64'(last_pop_addr), 64'(target));
            check_value("out.inst_id", last_pop_id, id_before + 64'd2);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            idle_run  = mem_req_valid ? 0 : idle_run + 1;
            req_fired = mem_req_valid && mem_req_ready;
            if (after_flush || redirect_valid) begin
                check_value("out_valid", 64'(out_valid), 64'd0);
            end
            after_flush = redirect_valid;
            if (redirect_valid) begin
                exp_addr = redirect_addr;
                exp_id   = exp_id + 64'd1;
            end else if (out_valid && out_ready) begin
                check_value("out.addr", 64'(out.addr), 64'(exp_addr));
                check_value("out.inst", 64'(out.inst), 64'(exp_addr ^ INST_KEY));
                check_value("out.inst_id", out.inst_id, exp_id);
                last_pop_addr = out.addr;
                last_pop_id   = out.inst_id;
                ref_pop_id    = exp_id;
                exp_addr      = exp_addr + 32'd4;
                exp_id        = exp_id + 64'd1;
                pop_count     = pop_count + 1;
            end
        end
    end

    initial begin
        int start_errors;
        int waited;
        int count_before;
        void'($urandom(32'ha9c2));
        clk = 1'b0;
        rst_n = 1'b0;
        redirect_valid = 1'b0;
        redirect_addr = '0;
        out_ready = 1'b0;
        hold_ready = 1'b0;
        inject_bad = 1'b0;
        exp_addr = RESET_PC;
        exp_id = '0;
        ref_pop_id = '0;
        last_pop_addr = '0;
        last_pop_id = '0;
        pop_count = 0;
        idle_run = 0;
        req_fired = 1'b0;
        after_flush = 1'b0;
        errors = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        start_errors = errors;
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("mem_req_valid", 64'(mem_req_valid), 64'd1);
        check_value("mem_req.addr", 64'(mem_req.addr), 64'(RESET_PC));
        pop_words(1, "first fetch after reset");
        check_value("out.addr", 64'(last_pop_addr), 64'(RESET_PC));
        check_value("out.inst_id", last_pop_id, 64'd0);
        report_test("1 reset", start_errors);

        start_errors = errors;
        pop_words(60, "sequential fetch");
        report_test("2 sequential", start_errors);

        start_errors = errors;
        out_ready = 1'b0;
        waited = 0;
        while (!timed_out && idle_run < 20) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: the queue never filled under back-pressure");
                timed_out = 1'b1;
            end
        end
        hold_ready = 1'b1;      // memory accepts nothing while the queue drains
        repeat (2) @(negedge clk);
        count_before = pop_count;
        out_ready = 1'b1;
        waited = 0;
        while (!timed_out && pop_count < count_before + 15) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: the full queue did not drain");
                timed_out = 1'b1;
            end
        end
        check_value("drain cycles", 64'(waited), 64'd15);
        repeat (6) @(negedge clk);
        check_value("words drained", 64'(pop_count - count_before), 64'd15);
        hold_ready = 1'b0;
        report_test("3 back-pressure", start_errors);

        start_errors = errors;
        for (int k = 0; k < 6; k++) begin
            pop_words($urandom_range(1, 8), "run before redirect");
            redirect_and_check(32'h0100_0000 * (k + 1) + ($urandom_range(0, 255) << 2));
        end
        report_test("4 redirect", start_errors);

        start_errors = errors;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            inject_bad = 1'b1;
            @(negedge clk);
            inject_bad = 1'b0;
            pop_words($urandom_range(1, 4), "run after injected response");
            wait_request();     // redirect while its answer is still in flight
            redirect_and_check(32'h0100_0000 * (k + 8) + ($urandom_range(0, 255) << 2));
        end
        pop_words(20, "final sequential run");
        report_test("5 stale responses", start_errors);

        $display("tests run: 5, tests failed: %0d, check errors: %0d", tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: compile.f
common/fetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/pc_unit.sv
fetch/fetch_queue.sv
source/fetch_top.sv
testbench/imem_model.sv
testbench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator, fail if the log reports errors
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --assert --top-module fetch_tb -f compile.f -o fetch_sim \
    && ./obj_dir/fetch_sim > "$log" 2>&1 \
    || { cat "$log" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$log"
grep -q "ERRORS FOUND" "$log" && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
